/* include/sublane_params.svh */
`ifndef SUBLANE_PARAMS_SVH
`define SUBLANE_PARAMS_SVH

// Lane geometry
`define SLD_VLANE_NUM       8
`define SLD_MEM_DEPTH       512     // VRF words in one lane

// Longest vector that one lane holds
`define SLD_MAX_VL_PER_LANE 256

`define SLD_VRF_READ_DELAY  4       // Read address to read data, in cycles

`endif

/* design/sublane_pkg.sv */
`include "sublane_params.svh"

package sublane_pkg;

    typedef logic [$clog2(`SLD_MEM_DEPTH)-1:0] lane_addr_t;
    typedef logic [$clog2(`SLD_VLANE_NUM*`SLD_MAX_VL_PER_LANE)-1:0] vl_t;
    typedef logic [$clog2(`SLD_MAX_VL_PER_LANE)+1:0] elem_cnt_t;  // Room for delay plus limit
    typedef logic [3:0] byte_en_t;
    typedef logic [1:0] byte_sel_t;

    // Encoding 3 is reserved
    typedef enum logic [1:0] {SEW_BYTE = 2'd0, SEW_HALF = 2'd1, SEW_WORD = 2'd2} sew_t;
    typedef enum logic [1:0] {INST_NORMAL, INST_STORE, INST_LOAD} inst_kind_t;
    typedef enum logic [1:0] {ST_IDLE, ST_NORMAL, ST_STORE, ST_LOAD} ctrl_state_t;

    typedef struct packed {
        inst_kind_t       kind;
        sew_t             rd_sew;
        sew_t             wr_sew;
        vl_t              vl;
        elem_cnt_t        inst_delay;    // Read issue to first write
        lane_addr_t       wr_base;
        lane_addr_t [1:0] rd_base;       // vs1, vs2
    } inst_cfg_t;

    typedef struct packed {
        logic             en;
        lane_addr_t [1:0] addr;
        byte_sel_t        byte_sel;
    } vrf_rd_port_t;

    typedef struct packed {
        logic                              en;
        lane_addr_t                        addr;
        byte_en_t [`SLD_VLANE_NUM-1:0]     bwen;
    } vrf_wr_port_t;

    // Clear/enable act on the current cycle, the rest on the cycle being issued
    typedef struct packed {
        logic cnt_clr;
        logic cnt_en;
        logic rd_active;
        logic wr_active;
        logic ld_active;
    } ctrl_flags_t;

endpackage

/* design/element_counter.sv */
`timescale 1ns/1ns
`include "sublane_params.svh"

module element_counter
    import sublane_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  ctrl_flags_t flags_i,
    input  inst_cfg_t   cfg_i,
    output elem_cnt_t   rd_idx_o,      // Index issued for the next cycle
    output elem_cnt_t   wr_idx_o,
    output logic        read_last_o,
    output logic        write_last_o
);

    localparam int LANE_BITS = $clog2(`SLD_VLANE_NUM);

    elem_cnt_t count_q, count_d;
    elem_cnt_t limit;

    // Elements per lane, rounded up
    assign limit = elem_cnt_t'(cfg_i.vl >> LANE_BITS) +
                   elem_cnt_t'(|cfg_i.vl[LANE_BITS-1:0]);

    assign count_d = flags_i.cnt_clr ? '0 : (flags_i.cnt_en ? count_q + 1'b1 : count_q);

    always_ff @(posedge clk_i) begin
        if (!rst_i)
            count_q <= '0;
        else
            count_q <= count_d;
    end

    assign rd_idx_o = count_d;
    assign wr_idx_o = flags_i.ld_active ? count_d : count_d - cfg_i.inst_delay;

    // Window ends, seen on the current cycle
    assign read_last_o  = flags_i.cnt_en && (count_q == limit - 1'b1);
    assign write_last_o = flags_i.cnt_en && (count_q == cfg_i.inst_delay + limit - 1'b1);

    a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_i)
        int'(count_q) <= `SLD_MAX_VL_PER_LANE + int'(cfg_i.inst_delay));

endmodule

/* design/sublane_ctrl_fsm.sv */
`timescale 1ns/1ns

module sublane_ctrl_fsm
    import sublane_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        start_i,
    input  inst_cfg_t   cfg_i,
    input  logic        load_last_i,
    input  logic        read_last_i,      // From element counter
    input  logic        write_last_i,
    output logic        ready_o,
    output inst_cfg_t   cfg_o,
    output ctrl_flags_t flags_o,
    output logic        store_data_valid_o,
    output logic        ready_for_load_o
);

    ctrl_state_t state_q, state_d;
    inst_cfg_t   cfg_q;
    logic        reads_done_q;
    logic        accept;

    assign ready_o = (state_q == ST_IDLE);
    assign accept  = start_i && ready_o;

    // Datapath sees the new instruction already in the accept cycle
    assign cfg_o = accept ? cfg_i : cfg_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cfg_q <= '0;
        end else if (accept) begin
            cfg_q <= cfg_i;
        end
    end

    //////////////////////////////////////////////////
    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    case (cfg_i.kind)
                        INST_NORMAL: state_d = ST_NORMAL;
                        INST_STORE:  state_d = ST_STORE;
                        INST_LOAD:   state_d = ST_LOAD;
                        default:     state_d = ST_IDLE;
                    endcase
                end
            end
            ST_NORMAL: begin
                if (write_last_i)
                    state_d = ST_IDLE;     // Last result written
            end
            ST_STORE: begin
                if (read_last_i)
                    state_d = ST_IDLE;
            end
            ST_LOAD: begin
                if (load_last_i)
                    state_d = ST_IDLE;     // Load unit ends the beat stream
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q      <= ST_IDLE;
            reads_done_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE)
                reads_done_q <= 1'b0;
            else if (read_last_i)
                reads_done_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Strobes to the datapath
    always_comb begin
        flags_o.cnt_clr   = (state_q == ST_IDLE);
        flags_o.cnt_en    = (state_q != ST_IDLE);
        flags_o.rd_active = (state_d == ST_NORMAL || state_d == ST_STORE) &&
                            !read_last_i && !reads_done_q;
        flags_o.wr_active = (state_d == ST_NORMAL || state_d == ST_LOAD);
        flags_o.ld_active = (state_d == ST_LOAD);
    end

    assign store_data_valid_o = (state_q == ST_STORE);
    assign ready_for_load_o   = (state_q == ST_LOAD);

    // Address generation has no meaning for the reserved width
    a_legal_sew: assert property (@(posedge clk_i) disable iff (!rst_i)
        accept |-> (2'(cfg_i.rd_sew) != 2'd3 && 2'(cfg_i.wr_sew) != 2'd3));

endmodule

/* design/vrf_port_gen.sv */
`timescale 1ns/1ns
`include "sublane_params.svh"

module vrf_port_gen
    import sublane_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  inst_cfg_t                     cfg_i,
    input  ctrl_flags_t                   flags_i,
    input  elem_cnt_t                     rd_idx_i,
    input  elem_cnt_t                     wr_idx_i,
    input  byte_en_t [`SLD_VLANE_NUM-1:0] load_bwen_i,
    output vrf_rd_port_t                  vrf_rd_o,
    output vrf_wr_port_t                  vrf_wr_o
);

    localparam int OFF_W = $bits(elem_cnt_t) + 2;

    function automatic logic [OFF_W-1:0] byte_offset(elem_cnt_t idx, sew_t sew);
        return {2'b00, idx} << sew;
    endfunction

    function automatic lane_addr_t word_addr(lane_addr_t base, logic [OFF_W-1:0] off);
        return base + lane_addr_t'(off[OFF_W-1:2]);
    endfunction

    logic [OFF_W-1:0] rd_off, wr_off;
    sew_t             wr_sew;
    byte_sel_t        wr_sel;
    byte_en_t         be_d;
    logic             wr_en_d;

    logic             rd_en_q, wr_en_q, ld_q;
    lane_addr_t [1:0] rd_addr_q;
    byte_sel_t        rd_sel_q;
    lane_addr_t       wr_addr_q;
    byte_en_t         be_q;

    //////////////////////////////////////////////////
    // Issue stage
    assign wr_sew  = flags_i.ld_active ? SEW_WORD : cfg_i.wr_sew;   // Loads fill whole words
    assign rd_off  = byte_offset(rd_idx_i, cfg_i.rd_sew);
    assign wr_off  = byte_offset(wr_idx_i, wr_sew);
    assign wr_sel  = wr_off[1:0];
    assign wr_en_d = flags_i.wr_active && (flags_i.ld_active || rd_idx_i >= cfg_i.inst_delay);

    always_comb begin
        case (wr_sew)
            SEW_BYTE: be_d = 4'b0001 << wr_sel;
            SEW_HALF: be_d = wr_sel[1] ? 4'b1100 : 4'b0011;
            default:  be_d = 4'b1111;
        endcase
        if (!wr_en_d)
            be_d = '0;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rd_en_q <= 1'b0;
            wr_en_q <= 1'b0;
            ld_q    <= 1'b0;
        end else begin
            rd_en_q <= flags_i.rd_active;
            wr_en_q <= wr_en_d;
            ld_q    <= flags_i.ld_active;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_addr_q[0] <= word_addr(cfg_i.rd_base[0], rd_off);
        rd_addr_q[1] <= word_addr(cfg_i.rd_base[1], rd_off);
        rd_sel_q     <= rd_off[1:0];
        wr_addr_q    <= word_addr(cfg_i.wr_base, wr_off);
        be_q         <= be_d;
    end

    //////////////////////////////////////////////////
    // Port outputs
    always_comb begin
        vrf_rd_o.en       = rd_en_q;
        vrf_rd_o.addr     = rd_addr_q;
        vrf_rd_o.byte_sel = rd_sel_q;
        vrf_wr_o.en       = wr_en_q;
        vrf_wr_o.addr     = wr_addr_q;
        for (int i = 0; i < `SLD_VLANE_NUM; i++)
            vrf_wr_o.bwen[i] = ld_q ? load_bwen_i[i] : be_q;   // Load beats pass straight
    end

    a_bwen_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        !vrf_wr_o.en |-> (vrf_wr_o.bwen == '0));

endmodule

/* design/read_valid_pipe.sv */
`timescale 1ns/1ns
`include "sublane_params.svh"

module read_valid_pipe
    import sublane_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  inst_cfg_t                 cfg_i,
    input  ctrl_flags_t               flags_i,
    input  elem_cnt_t                 rd_idx_i,
    output logic [`SLD_VLANE_NUM-1:0] valid_o
);

    // Stage 0 lines up with the read enable, then the VRF latency
    localparam int DEPTH = `SLD_VRF_READ_DELAY + 1;

    typedef logic [`SLD_VLANE_NUM-1:0] lane_mask_t;

    lane_mask_t              mask_d;
    lane_mask_t [DEPTH-1:0]  pipe_q;

    // Lane i holds element idx*lanes+i, which may fall past vl in the last row
    always_comb begin
        for (int i = 0; i < `SLD_VLANE_NUM; i++)
            mask_d[i] = flags_i.rd_active &&
                        (int'(rd_idx_i) * `SLD_VLANE_NUM + i < int'(cfg_i.vl));
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            pipe_q <= '0;
        end else begin
            pipe_q <= {pipe_q[DEPTH-2:0], mask_d};    // Several reads in flight
        end
    end

    assign valid_o = pipe_q[DEPTH-1];

endmodule

/* design/sublane_driver_top.sv */
`timescale 1ns/1ns
`include "sublane_params.svh"

module sublane_driver_top
    import sublane_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rst_i,

    // Instruction handshake
    input  logic                              start_i,
    input  inst_cfg_t                         cfg_i,
    output logic                              ready_o,

    // Load unit
    input  byte_en_t [`SLD_VLANE_NUM-1:0]     load_bwen_i,
    input  logic                              load_last_i,
    output logic                              ready_for_load_o,

    // VRF ports of all lanes
    output vrf_rd_port_t                      vrf_rd_o,
    output vrf_wr_port_t                      vrf_wr_o,
    output logic [`SLD_VLANE_NUM-1:0]         read_data_valid_o,
    output logic                              store_data_valid_o
);

    inst_cfg_t   cfg;
    ctrl_flags_t flags;
    elem_cnt_t   rd_idx;
    elem_cnt_t   wr_idx;
    logic        read_last;
    logic        write_last;

    //////////////////////////////////////////////////
    // Control
    sublane_ctrl_fsm ctrl_inst (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .cfg_i              (cfg_i),
        .load_last_i        (load_last_i),
        .read_last_i        (read_last),
        .write_last_i       (write_last),
        .ready_o            (ready_o),
        .cfg_o              (cfg),
        .flags_o            (flags),
        .store_data_valid_o (store_data_valid_o),
        .ready_for_load_o   (ready_for_load_o)
    );

    element_counter counter_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flags_i      (flags),
        .cfg_i        (cfg),
        .rd_idx_o     (rd_idx),
        .wr_idx_o     (wr_idx),
        .read_last_o  (read_last),
        .write_last_o (write_last)
    );

    //////////////////////////////////////////////////
    // Datapath
    vrf_port_gen port_gen_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cfg_i       (cfg),
        .flags_i     (flags),
        .rd_idx_i    (rd_idx),
        .wr_idx_i    (wr_idx),
        .load_bwen_i (load_bwen_i),
        .vrf_rd_o    (vrf_rd_o),
        .vrf_wr_o    (vrf_wr_o)
    );

    read_valid_pipe valid_pipe_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .cfg_i    (cfg),
        .flags_i  (flags),
        .rd_idx_i (rd_idx),
        .valid_o  (read_data_valid_o)
    );

endmodule

/* verif/sublane_checker.sv */
`timescale 1ns/1ns
`include "sublane_params.svh"

module sublane_checker
    import sublane_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          start_i,
    input  inst_cfg_t                     cfg_i,
    input  byte_en_t [`SLD_VLANE_NUM-1:0] load_bwen_i,
    input  logic                          load_last_i,
    input  logic                          ready_i,
    input  vrf_rd_port_t                  vrf_rd_i,
    input  vrf_wr_port_t                  vrf_wr_i,
    input  logic [`SLD_VLANE_NUM-1:0]     read_data_valid_i,
    input  logic                          store_data_valid_i,
    input  logic                          ready_for_load_i,
    output int                            errors_o,
    output int                            checks_o
);

    typedef struct packed {
        logic                          ready;
        logic                          rd_en;
        lane_addr_t [1:0]              rd_addr;
        byte_sel_t                     rd_sel;
        logic                          wr_en;
        lane_addr_t                    wr_addr;
        byte_en_t [`SLD_VLANE_NUM-1:0] bwen;
        logic [`SLD_VLANE_NUM-1:0]     valid;
        logic                          st_valid;
        logic                          ld_ready;
    } port_vals_t;

    inst_cfg_t  cfg_q;          // Last accepted instruction
    logic       have_inst;
    int         cyc;            // Cycles since acceptance
    int         load_end;       // Cycle of the last load beat, -1 while open
    port_vals_t exp_v;

    //////////////////////////////////////////////////
    // Reference model
    function automatic port_vals_t expected_ports(logic valid_inst, inst_cfg_t cfg, int t,
            int last_beat, byte_en_t [`SLD_VLANE_NUM-1:0] ld_be);
        port_vals_t e;
        int         limit;
        int         delay;
        int         off;
        int         row;
        int         lane;
        byte_en_t   be;
        e       = '0;
        e.ready = 1'b1;
        if (!valid_inst)
            return e;
        limit = (int'(cfg.vl) + `SLD_VLANE_NUM - 1) / `SLD_VLANE_NUM;
        delay = int'(cfg.inst_delay);
        case (cfg.kind)
            INST_NORMAL: begin
                e.rd_en = (t < limit);
                e.wr_en = (t >= delay) && (t < delay + limit);
                e.ready = (t >= delay + limit);
            end
            INST_STORE: begin
                e.rd_en    = (t < limit);
                e.st_valid = (t < limit);
                e.ready    = (t >= limit);
            end
            default: begin     // Load stays open until its last beat
                e.wr_en    = (last_beat < 0) || (t <= last_beat);
                e.ld_ready = e.wr_en;
                e.ready    = !e.wr_en;
            end
        endcase
        if (e.rd_en) begin
            off          = t * (1 << int'(cfg.rd_sew));
            e.rd_addr[0] = lane_addr_t'(int'(cfg.rd_base[0]) + off / 4);
            e.rd_addr[1] = lane_addr_t'(int'(cfg.rd_base[1]) + off / 4);
            e.rd_sel     = byte_sel_t'(off % 4);
        end
        if (e.wr_en && cfg.kind == INST_LOAD) begin
            e.wr_addr = lane_addr_t'(int'(cfg.wr_base) + t);     // One word per beat
            e.bwen    = ld_be;
        end else if (e.wr_en) begin
            off       = (t - delay) * (1 << int'(cfg.wr_sew));
            e.wr_addr = lane_addr_t'(int'(cfg.wr_base) + off / 4);
            case (cfg.wr_sew)
                SEW_BYTE: be = byte_en_t'(1 << (off % 4));
                SEW_HALF: be = (off % 4 == 2) ? 4'b1100 : 4'b0011;
                default:  be = 4'b1111;
            endcase
            for (lane = 0; lane < `SLD_VLANE_NUM; lane++)
                e.bwen[lane] = be;
        end
        // Read data of row r shows up VRF latency later
        row = t - `SLD_VRF_READ_DELAY;
        if (cfg.kind != INST_LOAD && row >= 0 && row < limit) begin
            for (lane = 0; lane < `SLD_VLANE_NUM; lane++)
                e.valid[lane] = (row * `SLD_VLANE_NUM + lane < int'(cfg.vl));
        end
        return e;
    endfunction

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        checks_o++;
        if (got !== exp) begin
            errors_o++;
            $display("ERR %s cycle %0d: got %h expected %h", name, cyc, got, exp);
        end
    endtask

    initial begin
        errors_o = 0;
        checks_o = 0;
    end

    //////////////////////////////////////////////////
    // Compare on the falling edge, inputs and outputs settled
    always @(negedge clk_i) begin
        if (!rst_i) begin
            have_inst = 1'b0;
            cyc       = 0;
            load_end  = -1;
        end else begin
            exp_v = expected_ports(have_inst, cfg_q, cyc, load_end, load_bwen_i);
            check_val("ready_o", ready_i, exp_v.ready);
            check_val("vrf_rd_o.en", vrf_rd_i.en, exp_v.rd_en);
            if (exp_v.rd_en) begin
                check_val("vrf_rd_o.addr[0]", vrf_rd_i.addr[0], exp_v.rd_addr[0]);
                check_val("vrf_rd_o.addr[1]", vrf_rd_i.addr[1], exp_v.rd_addr[1]);
                check_val("vrf_rd_o.byte_sel", vrf_rd_i.byte_sel, exp_v.rd_sel);
            end
            check_val("vrf_wr_o.en", vrf_wr_i.en, exp_v.wr_en);
            if (exp_v.wr_en)
                check_val("vrf_wr_o.addr", vrf_wr_i.addr, exp_v.wr_addr);
            check_val("vrf_wr_o.bwen", vrf_wr_i.bwen, exp_v.bwen);
            check_val("read_data_valid_o", read_data_valid_i, exp_v.valid);
            check_val("store_data_valid_o", store_data_valid_i, exp_v.st_valid);
            check_val("ready_for_load_o", ready_for_load_i, exp_v.ld_ready);

            if (have_inst && cfg_q.kind == INST_LOAD && load_end < 0 && load_last_i)
                load_end = cyc;
            if (start_i && exp_v.ready) begin      // Handshake taken on the next edge
                cfg_q     = cfg_i;
                have_inst = 1'b1;
                cyc       = 0;
                load_end  = -1;
            end else begin
                cyc++;
            end
        end
    end

endmodule

/* verif/tb_sublane_driver.sv */
`timescale 1ns/1ns
`include "sublane_params.svh"

module tb_sublane_driver
    import sublane_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int IDLE_GAP       = 6;      // Read-valid pipe drains in between

    logic                          clk_i;
    logic                          rst_i;
    logic                          start_i;
    inst_cfg_t                     cfg_i;
    byte_en_t [`SLD_VLANE_NUM-1:0] load_bwen_i;
    logic                          load_last_i;
    logic                          ready_o;
    vrf_rd_port_t                  vrf_rd_o;
    vrf_wr_port_t                  vrf_wr_o;
    logic [`SLD_VLANE_NUM-1:0]     read_data_valid_o;
    logic                          store_data_valid_o;
    logic                          ready_for_load_o;

    int          errors;
    int          checks;
    int          test_num;
    logic        timed_out;
    logic [31:0] rng_state;

    sublane_driver_top sublane_driver_top_inst (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .cfg_i              (cfg_i),
        .ready_o            (ready_o),
        .load_bwen_i        (load_bwen_i),
        .load_last_i        (load_last_i),
        .ready_for_load_o   (ready_for_load_o),
        .vrf_rd_o           (vrf_rd_o),
        .vrf_wr_o           (vrf_wr_o),
        .read_data_valid_o  (read_data_valid_o),
        .store_data_valid_o (store_data_valid_o)
    );

    sublane_checker check_inst (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .cfg_i              (cfg_i),
        .load_bwen_i        (load_bwen_i),
        .load_last_i        (load_last_i),
        .ready_i            (ready_o),
        .vrf_rd_i           (vrf_rd_o),
        .vrf_wr_i           (vrf_wr_o),
        .read_data_valid_i  (read_data_valid_o),
        .store_data_valid_i (store_data_valid_o),
        .ready_for_load_i   (ready_for_load_o),
        .errors_o           (errors),
        .checks_o           (checks)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic inst_cfg_t random_cfg(inst_kind_t kind);
        inst_cfg_t c;
        c.kind       = kind;
        c.rd_sew     = sew_t'(next_random() % 3);
        c.wr_sew     = sew_t'(next_random() % 3);
        c.vl         = vl_t'(1 + next_random() % 160);
        c.inst_delay = elem_cnt_t'(2 + next_random() % 10);   // Busy for at least 3 cycles
        c.wr_base    = lane_addr_t'(next_random());
        c.rd_base[0] = lane_addr_t'(next_random());
        c.rd_base[1] = lane_addr_t'(next_random());
        return c;
    endfunction

    task automatic wait_ready();
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (!ready_o && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            waited++;
        end
        if (!ready_o)
            timed_out = 1'b1;
    endtask

    // Returns right after the acceptance edge
    task automatic issue(inst_cfg_t cfg);
        wait_ready();
        if (timed_out)
            return;
        @(posedge clk_i);
        start_i <= 1'b1;
        cfg_i   <= cfg;
        @(posedge clk_i);
        start_i <= 1'b0;
        cfg_i   <= random_cfg(INST_NORMAL);    // DUT works from its latched copy
    endtask

    task automatic report(string name, int errs_before);
        if (timed_out)
            $display("test %0d %s: ready_o did not return within %0d cycles",
                     test_num, name, TIMEOUT_CYCLES);
        else if (errors == errs_before)
            $display("test %0d %s: ok", test_num, name);
        else
            $display("test %0d %s: failed, %0d mismatches", test_num, name,
                     errors - errs_before);
    endtask

    task automatic run_test(string name, inst_cfg_t cfg, logic poke_busy, int beats);
        int errs_before;
        int b;
        if (timed_out)
            return;
        errs_before = errors;
        test_num++;
        issue(cfg);
        if (!timed_out && cfg.kind == INST_LOAD) begin
            for (b = 0; b < beats; b++) begin
                if (b > 0)
                    @(posedge clk_i);
                load_bwen_i <= next_random();
                load_last_i <= (b == beats - 1);
            end
            @(posedge clk_i);
            load_last_i <= 1'b0;
            load_bwen_i <= '0;
        end else if (!timed_out && poke_busy) begin
            @(posedge clk_i);
            start_i <= 1'b1;                    // Must be ignored while busy
            cfg_i   <= random_cfg(INST_STORE);
            @(posedge clk_i);
            start_i <= 1'b0;
        end
        if (!timed_out)
            wait_ready();
        repeat (IDLE_GAP) @(posedge clk_i);
        report(name, errs_before);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    initial begin
        inst_cfg_t cfg;
        int        s;
        rng_state   = 32'hae70_accb;
        timed_out   = 1'b0;
        test_num    = 0;
        rst_i       = 1'b0;
        start_i     = 1'b0;
        cfg_i       = '0;
        load_bwen_i = '0;
        load_last_i = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b1;

        repeat (IDLE_GAP) @(posedge clk_i);
        test_num++;
        report("reset idle", 0);

        for (s = 0; s < 3; s++) begin
            cfg        = random_cfg(INST_NORMAL);
            cfg.rd_sew = sew_t'(s);
            cfg.wr_sew = sew_t'(2 - s);
            run_test("normal sew", cfg, 1'b1, 0);
        end

        cfg            = random_cfg(INST_NORMAL);
        cfg.vl         = vl_t'(64);
        cfg.inst_delay = '0;
        run_test("normal full rows", cfg, 1'b0, 0);

        cfg    = random_cfg(INST_NORMAL);
        cfg.vl = vl_t'(8 * (1 + next_random() % 15) + 1 + next_random() % 7);
        run_test("normal partial row", cfg, 1'b1, 0);

        cfg    = random_cfg(INST_NORMAL);
        cfg.vl = vl_t'(1);
        run_test("normal one elem", cfg, 1'b1, 0);

        run_test("store", random_cfg(INST_STORE), 1'b0, 0);
        run_test("store", random_cfg(INST_STORE), 1'b0, 0);

        cfg        = random_cfg(INST_LOAD);
        cfg.wr_sew = SEW_BYTE;                  // Loads still step by whole words
        run_test("load", cfg, 1'b0, 2 + int'(next_random() % 11));
        run_test("load", random_cfg(INST_LOAD), 1'b0, 1);

        $display("%0d tests, %0d checks, %0d mismatches", test_num, checks, errors);
        if (timed_out || errors != 0)
            $display("ERRORS FOUND");
        else
            $display("NO ERRORS");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
design/sublane_pkg.sv
design/element_counter.sv
design/sublane_ctrl_fsm.sv
design/vrf_port_gen.sv
design/read_valid_pipe.sv
design/sublane_driver_top.sv
verif/sublane_checker.sv
verif/tb_sublane_driver.sv

/* Bender.yml */
package:
  name: sublane_driver

export_include_dirs:
  - include

sources:
  - files:
      - design/sublane_pkg.sv
      - design/element_counter.sv
      - design/sublane_ctrl_fsm.sv
      - design/vrf_port_gen.sv
      - design/read_valid_pipe.sv
      - design/sublane_driver_top.sv

  - target: simulation
    files:
      - verif/sublane_checker.sv
      - verif/tb_sublane_driver.sv
